// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_neuron
FILELIST  ?= sim.f
LOG       ?= sim.log
PASS_MSG  := PASS: all tests
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== dot_product.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "neuron_params.svh"

module dot_product (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    term_valid,
  input  stream_pkg::term_t       term,
  output logic                    term_ready,

  output logic                    argument_valid,
  output fixed_point_pkg::fixed_t argument,
  input  logic                    argument_ready
);
  import fixed_point_pkg::*;

  accumulator_t accumulator;
  accumulator_t product;
  accumulator_t sum;
  logic         term_fire;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // multiply and add
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign term_fire = term_valid && term_ready;

  // full-width product, rescaled to 8 fraction bits.
  assign product = accumulator_t'(term.sample) * accumulator_t'(term.weight);
  assign sum     = accumulator + (product >>> `NEURON_FRAC_BITS);

  // no new terms while the argument waits.
  assign term_ready = !argument_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      accumulator <= '0;
    end else if (term_fire) begin
      accumulator <= term.last ? '0 : sum;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // argument output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      argument_valid <= 1'b0;
    end else if (term_fire && term.last) begin
      argument_valid <= 1'b1;
    end else if (argument_ready) begin
      argument_valid <= 1'b0;
    end
  end

  // clamp the vector's sum to 16 bits.
  always_ff @(posedge clock) begin
    if (term_fire && term.last) begin
      if (sum > accumulator_t'(fixed_max)) begin
        argument <= fixed_max;
      end else if (sum < accumulator_t'(fixed_min)) begin
        argument <= fixed_min;
      end else begin
        argument <= fixed_t'(sum);
      end
    end
  end

endmodule

`default_nettype wire

// ==== fixed_point_pkg.sv ====
`default_nettype none

package fixed_point_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // number types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // signed, 8 fraction bits.
  typedef logic signed [15:0] fixed_t;

  // unsigned fraction of one.
  typedef logic [7:0] activation_t;

  // running sum of the dot product.
  typedef logic signed [31:0] accumulator_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // limits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam fixed_t fixed_max = 16'sh7fff;
  localparam fixed_t fixed_min = 16'sh8000;

  // largest activation, just under one.
  localparam activation_t activation_max = 8'hff;

endpackage

`default_nettype wire

// ==== neuron.sv ====
`default_nettype none
`timescale 1ns/1ps

module neuron (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         train,

  input  logic                         term_valid,
  input  stream_pkg::term_t            term,
  output logic                         term_ready,

  output logic                         activation_valid,
  output fixed_point_pkg::activation_t activation,
  input  logic                         activation_ready,

  input  logic                         error_valid,
  input  fixed_point_pkg::fixed_t      error,
  output logic                         error_ready,

  output logic                         propagate_valid,
  output fixed_point_pkg::fixed_t      propagate,
  input  logic                         propagate_ready
);
  import fixed_point_pkg::*;

  // argument stream.
  logic        argument_valid;
  fixed_t      argument;
  logic        argument_ready;

  // sigmoid outputs ahead of the buffers.
  logic        sig_activation_valid;
  activation_t sig_activation;
  logic        sig_activation_ready;
  logic        sig_propagate_valid;
  fixed_t      sig_propagate;
  logic        sig_propagate_ready;

  dot_product u_dot_product (
    .clock          (clock),
    .reset          (reset),
    .term_valid     (term_valid),
    .term           (term),
    .term_ready     (term_ready),
    .argument_valid (argument_valid),
    .argument       (argument),
    .argument_ready (argument_ready)
  );

  sigmoid u_sigmoid (
    .clock            (clock),
    .reset            (reset),
    .train            (train),
    .argument_valid   (argument_valid),
    .argument         (argument),
    .argument_ready   (argument_ready),
    .activation_valid (sig_activation_valid),
    .activation       (sig_activation),
    .activation_ready (sig_activation_ready),
    .error_valid      (error_valid),
    .error            (error),
    .error_ready      (error_ready),
    .propagate_valid  (sig_propagate_valid),
    .propagate        (sig_propagate),
    .propagate_ready  (sig_propagate_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  stream_buffer #(.payload_t(activation_t)) u_activation_buffer (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (sig_activation_valid),
    .in_data   (sig_activation),
    .in_ready  (sig_activation_ready),
    .out_valid (activation_valid),
    .out_data  (activation),
    .out_ready (activation_ready)
  );

  stream_buffer #(.payload_t(fixed_t)) u_propagate_buffer (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (sig_propagate_valid),
    .in_data   (sig_propagate),
    .in_ready  (sig_propagate_ready),
    .out_valid (propagate_valid),
    .out_data  (propagate),
    .out_ready (propagate_ready)
  );

endmodule

`default_nettype wire

// ==== neuron_params.svh ====
`ifndef NEURON_PARAMS_SVH
`define NEURON_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-point format
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// fraction bits of every fixed-point number.
`define NEURON_FRAC_BITS 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sigmoid table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// beyond this magnitude the activation saturates.
`define SIGMOID_RANGE 6

// low argument bits used as table address.
`define SIGMOID_INDEX_BITS 12

`endif

// ==== sigmoid.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "neuron_params.svh"

module sigmoid (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        train,

  input  logic                        argument_valid,
  input  fixed_point_pkg::fixed_t     argument,
  output logic                        argument_ready,

  output logic                        activation_valid,
  output fixed_point_pkg::activation_t activation,
  input  logic                        activation_ready,

  input  logic                        error_valid,
  input  fixed_point_pkg::fixed_t     error,
  output logic                        error_ready,

  output logic                        propagate_valid,
  output fixed_point_pkg::fixed_t     propagate,
  input  logic                        propagate_ready
);
  import fixed_point_pkg::*;

  typedef enum logic [1:0] {
    st_argument,
    st_activation,
    st_error,
    st_propagate
  } state_t;

  localparam int     table_size = 2 ** `SIGMOID_INDEX_BITS;
  localparam real    frac_scale = real'(1 << `NEURON_FRAC_BITS);
  localparam fixed_t range_high = fixed_t'(`SIGMOID_RANGE <<< `NEURON_FRAC_BITS);
  localparam fixed_t range_low  = fixed_t'(-(`SIGMOID_RANGE <<< `NEURON_FRAC_BITS));

  function automatic real logistic(real x);
    return 1.0 / (1.0 + $exp(-x));
  endfunction

  activation_t        lookup_table [table_size];
  state_t             state;
  activation_t        result;
  activation_t        derivative;
  fixed_t             error_reg;
  logic [15:0]        slope;
  logic signed [31:0] scaled_error;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // activation table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // index read as a signed fixed-point argument.
  initial begin
    for (int index = 0; index < table_size; index++) begin
      int signed_index;
      signed_index = (index < table_size / 2) ? index : index - table_size;
      lookup_table[index] =
        activation_t'($rtoi(frac_scale * logistic(real'(signed_index) / frac_scale)));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_argument;
    end else begin
      case (state)
        st_argument:
          if (argument_valid && argument_ready) state <= st_activation;
        st_activation:
          // train decides whether an error step follows.
          if (activation_valid && activation_ready) state <= train ? st_error : st_argument;
        st_error:
          if (error_valid && error_ready) state <= st_propagate;
        st_propagate:
          if (propagate_valid && propagate_ready) state <= st_argument;
        default:
          state <= st_argument;
      endcase
    end
  end

  assign argument_ready = (state == st_argument);
  assign error_ready    = (state == st_error);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // forward path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (argument_valid && argument_ready) begin
      if (argument >= range_high) begin
        result <= activation_max;
      end else if (argument < range_low) begin
        result <= '0;
      end else begin
        result <= lookup_table[argument[`SIGMOID_INDEX_BITS-1:0]];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      activation_valid <= 1'b0;
    end else if (state == st_activation) begin
      if (!activation_valid) begin
        activation_valid <= 1'b1;
      end else if (activation_ready) begin
        activation_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_activation && !activation_valid) begin
      activation <= result;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // error path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a * (1 - a), at most 64.
  assign slope = {8'b0, result} * ((16'd1 << `NEURON_FRAC_BITS) - {8'b0, result});

  always_ff @(posedge clock) begin
    if (error_valid && error_ready) begin
      error_reg  <= error;
      derivative <= activation_t'(slope >> `NEURON_FRAC_BITS);
    end
  end

  assign scaled_error = error_reg * $signed({1'b0, derivative});

  always_ff @(posedge clock) begin
    if (reset) begin
      propagate_valid <= 1'b0;
    end else if (state == st_propagate) begin
      if (!propagate_valid) begin
        propagate_valid <= 1'b1;
      end else if (propagate_ready) begin
        propagate_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_propagate && !propagate_valid) begin
      propagate <= fixed_t'(scaled_error >>> `NEURON_FRAC_BITS);
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
fixed_point_pkg.sv
stream_pkg.sv
dot_product.sv
sigmoid.sv
stream_buffer.sv
neuron.sv
tb_neuron.sv

// ==== stream_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module stream_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic in_fire;

  // accept when empty or draining this cycle.
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one-entry register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one element of an input vector.
  // last marks the final pair of the vector.
  typedef struct packed {
    fixed_point_pkg::fixed_t sample;
    fixed_point_pkg::fixed_t weight;
    logic                    last;
  } term_t;

endpackage

`default_nettype wire

// ==== tb_neuron.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "neuron_params.svh"

module tb_neuron;
  import fixed_point_pkg::*;
  import stream_pkg::*;

  localparam int          random_vectors   = 40;
  localparam int          directed_vectors = 10;
  localparam int          train_vectors    = 40;
  localparam int          cycle_limit      =
    40 * (random_vectors + directed_vectors + train_vectors);
  localparam logic [31:0] seed             = 32'hcf6359c2;
  localparam int          range_limit      = `SIGMOID_RANGE << `NEURON_FRAC_BITS;
  localparam real         frac_scale       = real'(1 << `NEURON_FRAC_BITS);

  logic        clock;
  logic        reset;
  logic        train;
  logic        term_valid;
  term_t       term;
  logic        term_ready;
  logic        activation_valid;
  activation_t activation;
  logic        activation_ready;
  logic        error_valid;
  fixed_t      error;
  logic        error_ready;
  logic        propagate_valid;
  fixed_t      propagate;
  logic        propagate_ready;

  // reference model state.
  activation_t act_queue[$];
  activation_t train_queue[$];
  fixed_t      prop_queue[$];
  activation_t act_head;
  fixed_t      prop_head;
  int          act_pending;
  int          prop_pending;
  int          train_pending;
  int          model_sum;
  int          model_slope;
  activation_t model_act;

  logic [31:0] stim_rng;
  logic [31:0] ready_rng;
  logic [31:0] error_rng;
  int          cycle = 0;
  int          error_count = 0;
  int          activation_count = 0;
  int          propagate_count = 0;
  int          vectors_sent = 0;
  int          train_sent = 0;

  neuron u_neuron (
    .clock            (clock),
    .reset            (reset),
    .train            (train),
    .term_valid       (term_valid),
    .term             (term),
    .term_ready       (term_ready),
    .activation_valid (activation_valid),
    .activation       (activation),
    .activation_ready (activation_ready),
    .error_valid      (error_valid),
    .error            (error),
    .error_ready      (error_ready),
    .propagate_valid  (propagate_valid),
    .propagate        (propagate),
    .propagate_ready  (propagate_ready)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // galois form with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int count,
                           output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  function automatic fixed_t clamp_to_fixed(int sum);
    if (sum > 32767) return 16'sh7fff;
    if (sum < -32768) return 16'sh8000;
    return fixed_t'(sum);
  endfunction

  function automatic activation_t expected_activation(fixed_t argument);
    real x;
    if (int'(argument) >= range_limit) return 8'hff;
    if (int'(argument) < -range_limit) return 8'h00;
    x = real'(argument) / frac_scale;
    return activation_t'($rtoi(frac_scale * (1.0 / (1.0 + $exp(-x)))));
  endfunction

  // called on a falling edge and returns on the falling edge after the transfer.
  task automatic send_term(input fixed_t sample, input fixed_t weight, input logic last);
    term_valid  = 1'b1;
    term.sample = sample;
    term.weight = weight;
    term.last   = last;
    while (!term_ready) @(negedge clock);
    @(negedge clock);
    term_valid = 1'b0;
    if (last) begin
      vectors_sent++;
      if (train) train_sent++;
    end
  endtask

  // one to four terms with samples and weights within +-2.0.
  task automatic send_random_vector();
    logic [31:0] bits;
    int          length;
    fixed_t      sample;
    fixed_t      weight;
    draw_bits(stim_rng, 2, bits);
    length = int'(bits[1:0]) + 1;
    for (int k = 0; k < length; k++) begin
      draw_bits(stim_rng, 10, bits);
      sample = fixed_t'($signed(bits[9:0]));
      draw_bits(stim_rng, 10, bits);
      weight = fixed_t'($signed(bits[9:0]));
      draw_bits(stim_rng, 1, bits);
      if (bits[0]) @(negedge clock);
      send_term(sample, weight, k == length - 1);
    end
  endtask

  task automatic wait_drained();
    while (act_pending != 0 || prop_pending != 0 || train_pending != 0) begin
      @(negedge clock);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : main_sequence
    stim_rng   = seed;
    reset      = 1'b1;
    train      = 1'b0;
    term_valid = 1'b0;
    term       = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    repeat (random_vectors) send_random_vector();

    // sums beyond the 16-bit range.
    send_term(16'sh7fff, 16'sh7fff, 1'b1);
    send_term(16'sh7fff, 16'sh8000, 1'b1);
    send_term(16'sh7fff, 16'sh0200, 1'b1);
    send_term(16'sh7fff, 16'shfe00, 1'b1);
    repeat (3) send_term(16'sh4000, 16'sh0100, 1'b0);
    send_term(16'sh4000, 16'sh0100, 1'b1);
    // edges of the table range.
    send_term(16'sh0600, 16'sh0100, 1'b1);
    send_term(16'sh05ff, 16'sh0100, 1'b1);
    send_term(16'shfa00, 16'sh0100, 1'b1);
    send_term(16'shf9ff, 16'sh0100, 1'b1);
    send_term(16'sh0800, 16'shf800, 1'b1);
    wait_drained();

    train = 1'b1;
    repeat (train_vectors) send_random_vector();
    wait_drained();
    train = 1'b0;
    repeat (4) @(negedge clock);

    assert (activation_count == vectors_sent) else begin
      error_count++;
      $display("wrong number of activations received");
    end
    assert (propagate_count == train_sent) else begin
      error_count++;
      $display("wrong number of propagated errors received");
    end
    $display("errors: %0d, activations %0d of %0d, propagated errors %0d of %0d",
             error_count, activation_count, vectors_sent, propagate_count, train_sent);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // random back-pressure on both outputs.
  initial begin : ready_driver
    logic [31:0] bits;
    ready_rng        = seed;
    activation_ready = 1'b0;
    propagate_ready  = 1'b0;
    forever begin
      @(negedge clock);
      draw_bits(ready_rng, 1, bits);
      activation_ready = bits[0];
      draw_bits(ready_rng, 1, bits);
      propagate_ready = bits[0];
    end
  end

  // offers a fresh random error while training.
  initial begin : error_driver
    logic [31:0] bits;
    error_rng   = seed;
    error_valid = 1'b0;
    error       = '0;
    forever begin
      @(negedge clock);
      if (train && !reset) begin
        draw_bits(error_rng, 16, bits);
        error_valid = 1'b1;
        error       = fixed_t'(bits[15:0]);
        while (!error_ready) @(negedge clock);
      end else begin
        error_valid = 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout after %0d cycles, outputs still missing", cycle);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (reset) begin
      model_sum = 0;
    end else begin
      if (term_valid && term_ready) begin
        model_sum = model_sum +
          ((int'(term.sample) * int'(term.weight)) >>> `NEURON_FRAC_BITS);
        if (term.last) begin
          model_act = expected_activation(clamp_to_fixed(model_sum));
          act_queue.push_back(model_act);
          if (train) train_queue.push_back(model_act);
          model_sum = 0;
        end
      end
      // derivative a * (1 - a) and then error times derivative.
      if (error_valid && error_ready && train_queue.size() != 0) begin
        model_act   = train_queue.pop_front();
        model_slope = (int'(model_act) * (256 - int'(model_act))) >>> `NEURON_FRAC_BITS;
        prop_queue.push_back(fixed_t'((int'(error) * model_slope) >>> `NEURON_FRAC_BITS));
      end
      if (activation_valid && activation_ready) begin
        activation_count++;
        if (act_queue.size() != 0) void'(act_queue.pop_front());
      end
      if (propagate_valid && propagate_ready) begin
        propagate_count++;
        if (prop_queue.size() != 0) void'(prop_queue.pop_front());
      end
    end
    act_pending   = act_queue.size();
    prop_pending  = prop_queue.size();
    train_pending = train_queue.size();
    act_head      = (act_pending != 0) ? act_queue[0] : '0;
    prop_head     = (prop_pending != 0) ? prop_queue[0] : '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a finished vector blocks new terms while its argument waits.
  assert property (@(posedge clock) disable iff (reset)
      term_valid && term_ready && term.last |=> !term_ready)
    else begin
      error_count++;
      $display("%0t: term ready stayed high after the last term of a vector", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
      activation_valid && activation_ready && act_pending != 0 |-> activation == act_head)
    else begin
      error_count++;
      $display("[FAIL] %0t activation: expected %0d, got %0d",
               $time, $sampled(act_head), $sampled(activation));
    end

  assert property (@(posedge clock) disable iff (reset)
      activation_valid && activation_ready |-> act_pending != 0)
    else begin
      error_count++;
      $display("%0t: an activation arrived that no vector accounts for", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
      $past(activation_valid && !activation_ready) |-> activation_valid && $stable(activation))
    else begin
      error_count++;
      $display("%0t: activation dropped or changed while stalled", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
      propagate_valid && propagate_ready && prop_pending != 0 |-> propagate == prop_head)
    else begin
      error_count++;
      $display("[FAIL] %0t propagate: expected %0d, got %0d",
               $time, $sampled(prop_head), $sampled(propagate));
    end

  assert property (@(posedge clock) disable iff (reset)
      propagate_valid && propagate_ready |-> prop_pending != 0)
    else begin
      error_count++;
      $display("%0t: a propagated error arrived that no error accounts for", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
      $past(propagate_valid && !propagate_ready) |-> propagate_valid && $stable(propagate))
    else begin
      error_count++;
      $display("%0t: propagate dropped or changed while stalled", $time);
    end

  // no error step during inference.
  assert property (@(posedge clock) disable iff (reset)
      !train |-> !error_ready && !(propagate_valid && propagate_ready))
    else begin
      error_count++;
      $display("%0t: error stream active while train is low", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
      error_valid && error_ready |-> train_pending != 0)
    else begin
      error_count++;
      $display("%0t: an error was taken with no activation waiting for it", $time);
    end

  assert property (@(posedge clock)
      (reset && cycle != 0) || (!reset && $past(reset)) |->
        !activation_valid && !propagate_valid)
    else begin
      error_count++;
      $display("%0t: a valid output was high during or just after reset", $time);
    end

endmodule

`default_nettype wire
